//--- Bender.yml
package:
  name: csDecode

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/csDecodePkg.sv
      - rtl/opcodeMatch.sv
      - rtl/controlStore.sv
      - rtl/csDecode.sv
  - target: test
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/csDecodeTb.sv

//--- rtl/controlStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "csDecode_macros.svh"

module controlStore import csDecodePkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     matchValid,  // Stage-one result present
  input  logic     matchHit,
  input  csEntry_e matchEntry,  // Row index
  input  csOp_e    matchOp,     // Used by the group rows only
  output logic     outValid,    // matchValid delayed by one cycle
  output logic     hit,
  output csOp_e    op,
  output logic     size32,      // High for 32-bit operand size
  output logic     needsModrm,  // A ModRM byte follows the opcode
  output csImm_e   immSize,     // Immediate or displacement bytes after ModRM
  output logic     twoByte      // High for an 0F-prefixed opcode
);

  // One control-store row
  typedef struct packed {
    csOp_e  op;          // Fixed operation of the row
    logic   size32;
    logic   needsModrm;
    csImm_e immSize;
    logic   twoByte;
    logic   fromMatch;   // Row is shared by a group and takes matchOp instead of op
  } csRow_t;

  // Rows follow csEntry_e order, branches use the 32-bit EIP operand size
  localparam csRow_t RowTable [`CS_ENTRIES] = '{
    '{OP_ADD,  1'b0, 1'b0, IMM_NONE, 1'b0, 1'b0},  // ENT_NONE gives all zero
    '{OP_ADD,  1'b0, 1'b0, IMM_8,    1'b0, 1'b1},  // ENT_ALU_ACC8
    '{OP_ADD,  1'b1, 1'b0, IMM_32,   1'b0, 1'b1},  // ENT_ALU_ACC32
    '{OP_ADD,  1'b0, 1'b1, IMM_8,    1'b0, 1'b1},  // ENT_ALU_IMM8, also C0
    '{OP_ADD,  1'b1, 1'b1, IMM_32,   1'b0, 1'b1},  // ENT_ALU_IMM32
    '{OP_ADD,  1'b1, 1'b1, IMM_8,    1'b0, 1'b1},  // ENT_ALU_IMM8X, also C1
    '{OP_ADD,  1'b0, 1'b1, IMM_NONE, 1'b0, 1'b1},  // ENT_ALU_RM8, also XCHG 86
    '{OP_ADD,  1'b1, 1'b1, IMM_NONE, 1'b0, 1'b1},  // ENT_ALU_RM32
    '{OP_MOV,  1'b0, 1'b1, IMM_NONE, 1'b0, 1'b0},  // ENT_MOV_RM8
    '{OP_MOV,  1'b1, 1'b1, IMM_NONE, 1'b0, 1'b0},  // ENT_MOV_RM32
    '{OP_MOV,  1'b0, 1'b0, IMM_8,    1'b0, 1'b0},  // ENT_MOV_R8I
    '{OP_MOV,  1'b1, 1'b0, IMM_32,   1'b0, 1'b0},  // ENT_MOV_R32I
    '{OP_MOV,  1'b0, 1'b1, IMM_8,    1'b0, 1'b0},  // ENT_MOV_RM8I
    '{OP_MOV,  1'b1, 1'b1, IMM_32,   1'b0, 1'b0},  // ENT_MOV_RM32I
    '{OP_PUSH, 1'b1, 1'b0, IMM_NONE, 1'b0, 1'b0},  // ENT_PUSH_R
    '{OP_POP,  1'b1, 1'b0, IMM_NONE, 1'b0, 1'b0},  // ENT_POP_R
    '{OP_JMP,  1'b1, 1'b0, IMM_8,    1'b0, 1'b0},  // ENT_JMP8
    '{OP_JMP,  1'b1, 1'b0, IMM_32,   1'b0, 1'b0},  // ENT_JMP32
    '{OP_CALL, 1'b1, 1'b0, IMM_32,   1'b0, 1'b0},  // ENT_CALL32
    '{OP_RET,  1'b1, 1'b0, IMM_NONE, 1'b0, 1'b0},  // ENT_RET
    '{OP_RET,  1'b1, 1'b0, IMM_16,   1'b0, 1'b0},  // ENT_RETI
    '{OP_ADD,  1'b0, 1'b1, IMM_NONE, 1'b0, 1'b1},  // ENT_SHIFT8
    '{OP_ADD,  1'b1, 1'b1, IMM_NONE, 1'b0, 1'b1},  // ENT_SHIFT32
    '{OP_NOT,  1'b0, 1'b1, IMM_NONE, 1'b0, 1'b0},  // ENT_NOT8
    '{OP_NOT,  1'b1, 1'b1, IMM_NONE, 1'b0, 1'b0},  // ENT_NOT32
    '{OP_XCHG, 1'b1, 1'b0, IMM_NONE, 1'b0, 1'b0},  // ENT_XCHG_ACC
    '{OP_XCHG, 1'b1, 1'b1, IMM_NONE, 1'b0, 1'b0},  // ENT_XCHG_RM
    '{OP_JCC,  1'b1, 1'b0, IMM_8,    1'b0, 1'b0},  // ENT_JNE8
    '{OP_JCC,  1'b1, 1'b0, IMM_32,   1'b1, 1'b0}   // ENT_JNE32
  };

  csRow_t rowSel;  // Row addressed by the stage-one entry
  csOp_e  opSel;

  assign rowSel = RowTable[matchEntry];
  assign opSel  = rowSel.fromMatch ? matchOp : rowSel.op;  // Groups were resolved upstream

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      hit      <= 1'b0;
    end else begin
      outValid <= matchValid;
      hit      <= matchValid && matchHit;
    end
  end

  // Fields hold between lookups and are only meaningful with outValid
  always_ff @(posedge clk) begin
    if (matchValid) begin
      op         <= opSel;
      size32     <= rowSel.size32;
      needsModrm <= rowSel.needsModrm;
      immSize    <= rowSel.immSize;
      twoByte    <= rowSel.twoByte;
    end
  end

  // A hit from stage one must name a real row and a miss must read the all-zero row
  aEntryAgreesHit: assert property (@(posedge clk) disable iff (rst)
    matchValid |-> (matchHit == (matchEntry != ENT_NONE)))
    else $error("controlStore: matchHit disagrees with entry %0d", matchEntry);

endmodule

`default_nettype wire

//--- rtl/csDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "csDecode_macros.svh"

module csDecode import csDecodePkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,     // Strobe, may be high on back-to-back cycles
  input  logic [`CS_BYTE_W-1:0] byte1,
  input  logic [`CS_BYTE_W-1:0] byte2,
  output logic                  outValid,    // Two cycles after inValid
  output logic                  hit,
  output csOp_e                 op,
  output logic                  size32,
  output logic                  needsModrm,
  output csImm_e                immSize,
  output logic                  twoByte
);

  logic     matchValid;  // Stage one to stage two
  logic     matchHit;
  csEntry_e matchEntry;
  csOp_e    matchOp;

  // Pattern match and group resolution
  opcodeMatch opcodeMatch_i (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .byte1      (byte1),
    .byte2      (byte2),
    .matchValid (matchValid),
    .matchHit   (matchHit),
    .matchEntry (matchEntry),
    .matchOp    (matchOp)
  );

  // Row readout
  controlStore controlStore_i (
    .clk        (clk),
    .rst        (rst),
    .matchValid (matchValid),
    .matchHit   (matchHit),
    .matchEntry (matchEntry),
    .matchOp    (matchOp),
    .outValid   (outValid),
    .hit        (hit),
    .op         (op),
    .size32     (size32),
    .needsModrm (needsModrm),
    .immSize    (immSize),
    .twoByte    (twoByte)
  );

endmodule

`default_nettype wire

//--- rtl/csDecodePkg.sv
`default_nettype none

`include "csDecode_macros.svh"

package csDecodePkg;

  // One value per kept instruction family, used directly as the control-store row index
  typedef enum logic [`CS_IDX_W-1:0] {
    ENT_NONE = '0,   // No pattern matched
    ENT_ALU_ACC8,    // 04, 0C, 24 with imm8 on AL
    ENT_ALU_ACC32,   // 05, 0D, 25 with imm32 on EAX
    ENT_ALU_IMM8,    // 80 group, also C0 shifts since the row shape is the same
    ENT_ALU_IMM32,   // 81 group
    ENT_ALU_IMM8X,   // 83 group, also C1 shifts
    ENT_ALU_RM8,     // Even register forms of the ALU block, also XCHG 86
    ENT_ALU_RM32,    // Odd register forms of the ALU block
    ENT_MOV_RM8,     // 88 and 8A
    ENT_MOV_RM32,    // 89 and 8B
    ENT_MOV_R8I,     // B0 to B7
    ENT_MOV_R32I,    // B8 to BF
    ENT_MOV_RM8I,    // C6
    ENT_MOV_RM32I,   // C7
    ENT_PUSH_R,      // 50 to 57
    ENT_POP_R,       // 58 to 5F
    ENT_JMP8,        // EB
    ENT_JMP32,       // E9
    ENT_CALL32,      // E8
    ENT_RET,         // C3
    ENT_RETI,        // C2 pops imm16 extra bytes
    ENT_SHIFT8,      // D0 and D2 with reg 4 or 7
    ENT_SHIFT32,     // D1 and D3 with reg 4 or 7
    ENT_NOT8,        // F6 /2
    ENT_NOT32,       // F7 /2
    ENT_XCHG_ACC,    // 90 to 97
    ENT_XCHG_RM,     // 87
    ENT_JNE8,        // 75
    ENT_JNE32        // 0F 85
  } csEntry_e;

  // Operation handed to the execute stage
  typedef enum logic [3:0] {
    OP_ADD,    // Zero code, also the value carried on a miss
    OP_AND,
    OP_OR,
    OP_MOV,
    OP_PUSH,
    OP_POP,
    OP_JMP,
    OP_JCC,    // Conditional branch, only NE is decoded
    OP_CALL,
    OP_RET,
    OP_SAL,
    OP_SAR,
    OP_NOT,
    OP_XCHG
  } csOp_e;

  // Size of the immediate or displacement that follows the opcode and ModRM
  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_8,
    IMM_16,
    IMM_32
  } csImm_e;

endpackage

`default_nettype wire

//--- rtl/csDecode_macros.svh
`ifndef CS_DECODE_MACROS_SVH
`define CS_DECODE_MACROS_SVH

// Opcode byte width, both bytes of the lookup window use it
`define CS_BYTE_W 8

// ModRM reg field width
`define CS_REG_W 3

// Lowest bit of the reg field inside the second byte (bits 5 to 3)
`define CS_REG_LSB 3

// Rows in the control store, one per csEntry_e value including ENT_NONE
`define CS_ENTRIES 29

// Bits needed to index a control-store row
`define CS_IDX_W 5

`endif

//--- rtl/opcodeMatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "csDecode_macros.svh"

module opcodeMatch import csDecodePkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,     // One lookup per high cycle
  input  logic [`CS_BYTE_W-1:0] byte1,       // First opcode byte
  input  logic [`CS_BYTE_W-1:0] byte2,       // ModRM or second opcode byte after 0F
  output logic                  matchValid,  // inValid delayed by one cycle
  output logic                  matchHit,    // Some kept pattern matched
  output csEntry_e              matchEntry,  // Control-store row to read
  output csOp_e                 matchOp      // Resolved operation for the group rows
);

  logic [`CS_REG_W-1:0]   regField;    // ModRM reg field of the second byte
  logic [`CS_REG_W-1:0]   aluField;    // Bits 5 to 3 of byte1 name the op in the 00-3F block
  logic                   aluBlock;    // byte1 is one of 00-05, 08-0D, 20-25
  logic                   aluImmGrp;   // 80, 81 or 83 with reg 0, 1 or 4
  logic                   shiftGrp;    // D0-D3, C0 or C1 with reg 4 or 7
  logic [`CS_ENTRIES-1:0] entHit;      // One bit per control-store row
  logic                   anyHit;
  csEntry_e               entryNext;
  csOp_e                  opNext;

  // Codes 0, 1 and 4 are the ADD, OR and AND slots in both the opcode and the reg field
  function automatic logic isAluCode(input logic [`CS_REG_W-1:0] code);
    return (code == 3'd0) || (code == 3'd1) || (code == 3'd4);
  endfunction

  function automatic csOp_e aluOp(input logic [`CS_REG_W-1:0] code);
    csOp_e result;
    case (code)
      3'd0:    result = OP_ADD;
      3'd1:    result = OP_OR;
      default: result = OP_AND;  // Only 4 reaches here once isAluCode has passed
    endcase
    return result;
  endfunction

  assign regField = byte2[`CS_REG_LSB +: `CS_REG_W];
  assign aluField = byte1[5:3];

  assign aluBlock  = (byte1[7:6] == 2'b00) && isAluCode(aluField) &&
                     (byte1[2:0] <= 3'd5);                 // 06, 07 and 0F fall out here
  assign aluImmGrp = ((byte1 == 8'h80) || (byte1 == 8'h81) || (byte1 == 8'h83)) &&
                     isAluCode(regField);
  assign shiftGrp  = ((byte1[7:2] == 6'b110100) || (byte1[7:1] == 7'b1100000)) &&
                     ((regField == 3'd4) || (regField == 3'd7));

  // Patterns that share a row are exclusive on byte1, so OR-ing them keeps one hot
  always_comb begin
    entHit = '0;
    entHit[ENT_ALU_ACC8]  = aluBlock && (byte1[2:0] == 3'b100);
    entHit[ENT_ALU_ACC32] = aluBlock && (byte1[2:0] == 3'b101);
    entHit[ENT_ALU_IMM8]  = (aluImmGrp && (byte1 == 8'h80)) ||
                            (shiftGrp && (byte1 == 8'hC0));  // C0 has the 80 row shape
    entHit[ENT_ALU_IMM32] = aluImmGrp && (byte1 == 8'h81);
    entHit[ENT_ALU_IMM8X] = (aluImmGrp && (byte1 == 8'h83)) ||
                            (shiftGrp && (byte1 == 8'hC1));  // C1 has the 83 row shape
    entHit[ENT_ALU_RM8]   = (aluBlock && !byte1[2] && !byte1[0]) ||
                            (byte1 == 8'h86);                // XCHG r/m8 reuses the 8-bit r/m row
    entHit[ENT_ALU_RM32]  = aluBlock && !byte1[2] && byte1[0];
    entHit[ENT_MOV_RM8]   = (byte1[7:2] == 6'b100010) && !byte1[0];  // 88, 8A
    entHit[ENT_MOV_RM32]  = (byte1[7:2] == 6'b100010) && byte1[0];   // 89, 8B
    entHit[ENT_MOV_R8I]   = byte1[7:3] == 5'b10110;   // +r range folded to one row
    entHit[ENT_MOV_R32I]  = byte1[7:3] == 5'b10111;
    entHit[ENT_MOV_RM8I]  = byte1 == 8'hC6;
    entHit[ENT_MOV_RM32I] = byte1 == 8'hC7;
    entHit[ENT_PUSH_R]    = byte1[7:3] == 5'b01010;
    entHit[ENT_POP_R]     = byte1[7:3] == 5'b01011;
    entHit[ENT_JMP8]      = byte1 == 8'hEB;
    entHit[ENT_JMP32]     = byte1 == 8'hE9;
    entHit[ENT_CALL32]    = byte1 == 8'hE8;
    entHit[ENT_RET]       = byte1 == 8'hC3;
    entHit[ENT_RETI]      = byte1 == 8'hC2;
    entHit[ENT_SHIFT8]    = shiftGrp && (byte1[7:4] == 4'hD) && !byte1[0];  // D0, D2
    entHit[ENT_SHIFT32]   = shiftGrp && (byte1[7:4] == 4'hD) && byte1[0];   // D1, D3
    entHit[ENT_NOT8]      = (byte1 == 8'hF6) && (regField == 3'd2);  // Other F6 members are not kept
    entHit[ENT_NOT32]     = (byte1 == 8'hF7) && (regField == 3'd2);
    entHit[ENT_XCHG_ACC]  = byte1[7:3] == 5'b10010;
    entHit[ENT_XCHG_RM]   = byte1 == 8'h87;
    entHit[ENT_JNE8]      = byte1 == 8'h75;
    entHit[ENT_JNE32]     = (byte1 == 8'h0F) && (byte2 == 8'h85);  // Only two-byte opcode kept
  end

  assign anyHit = |entHit;

  // Encode the one-hot row vector, ENT_NONE stays when nothing hit
  always_comb begin
    entryNext = ENT_NONE;
    for (int i = 1; i < `CS_ENTRIES; i++) begin
      if (entHit[i]) entryNext = csEntry_e'(i[`CS_IDX_W-1:0]);
    end
  end

  // Group members are told apart here, the store only knows the row shape
  always_comb begin
    opNext = OP_ADD;                                     // Misses and fixed rows carry zero
    if (aluBlock) opNext = aluOp(aluField);              // Opcode bits pick ADD, OR or AND
    if (aluImmGrp) opNext = aluOp(regField);             // Reg field picks it for 80, 81, 83
    if (shiftGrp) opNext = (regField == 3'd4) ? OP_SAL : OP_SAR;
    if (byte1 == 8'h86) opNext = OP_XCHG;                // Shares ENT_ALU_RM8 with the ALU ops
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      matchValid <= 1'b0;
      matchHit   <= 1'b0;
    end else begin
      matchValid <= inValid;
      matchHit   <= inValid && anyHit;  // Low on idle cycles as well as on misses
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      matchEntry <= entryNext;
      matchOp    <= opNext;
    end
  end

  // The row table holds one row per family, so two hits would mean overlapping patterns
  aOneMatch: assert property (@(posedge clk) disable iff (rst)
    inValid |-> $onehot0(entHit))
    else $error("opcodeMatch: several patterns hit for %h %h", byte1, byte2);

endmodule

`default_nettype wire

//--- testbench/csDecodeTests.svh
`ifndef CS_DECODE_TESTS_SVH
`define CS_DECODE_TESTS_SVH

// Expected fields for one byte pair, taken from the kept part of the x86 opcode map
function automatic void modelDecode(input logic [7:0] b1, input logic [7:0] b2,
                                    output logic eHit, output csOp_e eOp,
                                    output logic eSize, output logic eModrm,
                                    output csImm_e eImm, output logic eTwo);
  logic [2:0] rf;
  rf = b2[5:3];             // ModRM reg field
  eHit = 1'b1;
  eOp = OP_MOV;
  eSize = 1'b1;             // Stack ops and branches run at 32 bits
  eModrm = 1'b0;
  eImm = IMM_NONE;
  eTwo = 1'b0;
  casez (b1)
    8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h08, 8'h09, 8'h0A, 8'h0B, 8'h0C, 8'h0D,
    8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h25: begin
      eOp = (b1 < 8'h08) ? OP_ADD : ((b1 < 8'h20) ? OP_OR : OP_AND);
      eSize = b1[0];
      eModrm = (b1[2:0] < 3'd4);                     // Columns 4 and 5 are the AL/EAX forms
      eImm = (b1[2:0] < 3'd4) ? IMM_NONE : (b1[0] ? IMM_32 : IMM_8);
    end
    8'h80, 8'h81, 8'h83: begin
      case (rf)
        3'd0: eOp = OP_ADD;
        3'd1: eOp = OP_OR;
        3'd4: eOp = OP_AND;
        default: eHit = 1'b0;                        // ADC, SBB, SUB, XOR and CMP are not kept
      endcase
      eSize = (b1 != 8'h80);
      eModrm = 1'b1;
      eImm = (b1 == 8'h81) ? IMM_32 : IMM_8;         // 83 sign-extends a byte
    end
    8'h88, 8'h89, 8'h8A, 8'h8B, 8'h86, 8'h87, 8'hC6, 8'hC7, 8'hF6, 8'hF7: begin
      eOp = (b1[7:4] == 4'hF) ? OP_NOT :
            (((b1[7:4] == 4'h8) && (b1[3:1] == 3'b011)) ? OP_XCHG : OP_MOV);
      eHit = (b1[7:4] != 4'hF) || (rf == 3'd2);      // Only NOT of the F6/F7 group
      eSize = b1[0];
      eModrm = 1'b1;
      eImm = (b1[7:4] != 4'hC) ? IMM_NONE : (b1[0] ? IMM_32 : IMM_8);
    end
    8'b1011_????: begin                              // MOV reg, imm with bit 3 giving size
      eSize = b1[3];
      eImm = b1[3] ? IMM_32 : IMM_8;
    end
    8'b0101_????: eOp = b1[3] ? OP_POP : OP_PUSH;
    8'b1001_0???: eOp = OP_XCHG;                     // XCHG EAX, reg
    8'hEB, 8'hE9, 8'hE8, 8'hC3, 8'hC2, 8'h75: begin
      eOp = (b1 == 8'h75) ? OP_JCC : ((b1[7:4] == 4'hC) ? OP_RET :
            ((b1 == 8'hE8) ? OP_CALL : OP_JMP));
      eImm = (b1 == 8'hC3) ? IMM_NONE : ((b1 == 8'hC2) ? IMM_16 :
             (((b1 == 8'hEB) || (b1 == 8'h75)) ? IMM_8 : IMM_32));
    end
    8'h0F: begin
      eHit = (b2 == 8'h85);                          // JNE rel32 is the only two-byte opcode
      eOp = OP_JCC;
      eImm = IMM_32;
      eTwo = 1'b1;
    end
    8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hC0, 8'hC1: begin
      eHit = (rf == 3'd4) || (rf == 3'd7);
      eOp = (rf == 3'd4) ? OP_SAL : OP_SAR;
      eSize = b1[0];
      eModrm = 1'b1;
      eImm = (b1[7:4] == 4'hC) ? IMM_8 : IMM_NONE;   // C0 and C1 carry the count byte
    end
    default: eHit = 1'b0;
  endcase
  if (!eHit) begin
    eOp = OP_ADD;
    eSize = 1'b0;
    eModrm = 1'b0;
    eImm = IMM_NONE;
    eTwo = 1'b0;
  end
endfunction

function automatic logic [7:0] modrmWithReg(input logic [2:0] regField);
  logic [7:0] r;
  r = 8'($urandom);
  return {r[7:6], regField, r[2:0]};
endfunction

function automatic logic [7:0] anyByte();
  return 8'($urandom);
endfunction

task automatic checkResult(input logic [7:0] b1, input logic [7:0] b2);
  logic   eHit;
  logic   eSize;
  logic   eModrm;
  logic   eTwo;
  csOp_e  eOp;
  csImm_e eImm;
  modelDecode(b1, b2, eHit, eOp, eSize, eModrm, eImm, eTwo);
  curBytes = {b1, b2};
  checkBit("hit", hit, eHit);
  checkOp(op, eOp);
  checkBit("size32", size32, eSize);
  checkBit("needsModrm", needsModrm, eModrm);
  checkImm(immSize, eImm);
  checkBit("twoByte", twoByte, eTwo);
endtask

// One strobe, result expected on the second rising edge and checked at the falling one
task automatic lookupOne(input logic [7:0] b1, input logic [7:0] b2);
  @(negedge clk);
  inValid = 1'b1;
  byte1 = b1;
  byte2 = b2;
  @(negedge clk);
  inValid = 1'b0;
  if (outValid) begin
    handshakeErrors++;
    $display("outValid rose one cycle early for bytes %h %h", b1, b2);
  end
  @(negedge clk);
  if (!outValid) begin
    handshakeErrors++;
    $display("outValid missing two cycles after the strobe for bytes %h %h", b1, b2);
  end else begin
    checkResult(b1, b2);
  end
endtask

task automatic testAlu();
  logic [7:0] accOps [6];
  logic [2:0] aluRegs [3];
  accOps = '{8'h04, 8'h24, 8'h0C, 8'h05, 8'h25, 8'h0D};
  aluRegs = '{3'd0, 3'd4, 3'd1};
  foreach (accOps[i]) begin
    lookupOne(accOps[i], anyByte());
  end
  foreach (aluRegs[i]) begin
    lookupOne(8'h80, modrmWithReg(aluRegs[i]));
    lookupOne(8'h81, modrmWithReg(aluRegs[i]));
    lookupOne(8'h83, modrmWithReg(aluRegs[i]));
  end
  for (int i = 0; i < 4; i++) begin
    lookupOne(8'(8'h00 + i), anyByte());
    lookupOne(8'(8'h20 + i), anyByte());
    lookupOne(8'(8'h08 + i), anyByte());
  end
endtask

task automatic testMov();
  for (int i = 0; i < 4; i++) begin
    lookupOne(8'(8'h88 + i), anyByte());
  end
  for (int i = 0; i < 16; i++) begin
    lookupOne(8'(8'hB0 + i), anyByte());
    lookupOne(8'(8'h50 + i), anyByte());
  end
  lookupOne(8'hC6, anyByte());
  lookupOne(8'hC7, anyByte());
  repeat (6) begin
    lookupOne(8'h90 + 8'(3'($urandom)), anyByte());  // Random +r register
  end
  lookupOne(8'h86, anyByte());
  lookupOne(8'h87, anyByte());
endtask

task automatic testControl();
  lookupOne(8'hEB, anyByte());
  lookupOne(8'hE9, anyByte());
  lookupOne(8'hE8, anyByte());
  lookupOne(8'hC3, anyByte());
  lookupOne(8'hC2, anyByte());
  lookupOne(8'h75, anyByte());
  lookupOne(8'h0F, 8'h85);
endtask

task automatic testShiftNot();
  logic [7:0] shiftOps [6];
  shiftOps = '{8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hC0, 8'hC1};
  foreach (shiftOps[i]) begin
    lookupOne(shiftOps[i], modrmWithReg(3'd4));
    lookupOne(shiftOps[i], modrmWithReg(3'd7));
  end
  lookupOne(8'hF6, modrmWithReg(3'd2));
  lookupOne(8'hF7, modrmWithReg(3'd2));
endtask

task automatic testMiss();
  lookupOne(8'h0F, 8'h6F);
  lookupOne(8'hFC, anyByte());
  lookupOne(8'hF4, anyByte());
  lookupOne(8'h9A, anyByte());
  lookupOne(8'h80, modrmWithReg(3'd2));
  lookupOne(8'hFF, modrmWithReg(3'd2));
  lookupOne(8'hF6, modrmWithReg(3'd0));
endtask

// Strobes on ten consecutive cycles, each result due exactly two cycles later
task automatic testBackToBack();
  logic [15:0] pairs [10];
  pairs = '{16'h0000, 16'h0F6F, 16'hB300, 16'hFC00, 16'h83E0,
            16'h9A00, 16'h0F85, 16'hD1F8, 16'hF6C0, 16'hC208};
  for (int i = 0; i < 12; i++) begin
    @(negedge clk);
    if ((i >= 2) && !outValid) begin
      handshakeErrors++;
      $display("outValid missing for burst lookup %0d", i - 2);
    end else if (i >= 2) begin
      checkResult(pairs[i - 2][15:8], pairs[i - 2][7:0]);
    end else if (outValid) begin
      handshakeErrors++;
      $display("outValid high before the first burst result was due");
    end
    inValid = (i < 10);
    if (i < 10) begin
      {byte1, byte2} = pairs[i];
    end
  end
  @(negedge clk);
  if (outValid) begin
    handshakeErrors++;
    $display("outValid stayed high after the last burst result");
  end
endtask

`endif

//--- testbench/csDecodeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csDecode_macros.svh"

module csDecodeTb import csDecodePkg::*; ();

  // Some 110 lookups of 3 cycles plus the burst finish near 350 cycles
  localparam int TimeoutCycles = 2000;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  inValid;
  logic [`CS_BYTE_W-1:0] byte1;
  logic [`CS_BYTE_W-1:0] byte2;
  logic                  outValid;
  logic                  hit;
  csOp_e                 op;
  logic                  size32;
  logic                  needsModrm;
  csImm_e                immSize;
  logic                  twoByte;

  int unsigned valueErrors = 0;      // Wrong field values
  int unsigned handshakeErrors = 0;  // Missing, early or extra outValid pulses
  int unsigned cycleCount = 0;
  logic [15:0] curBytes;             // Byte pair whose result is on the outputs

  always #4 clk = ~clk;  // 8 ns period

  csDecode dut_i (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .byte1      (byte1),
    .byte2      (byte2),
    .outValid   (outValid),
    .hit        (hit),
    .op         (op),
    .size32     (size32),
    .needsModrm (needsModrm),
    .immSize    (immSize),
    .twoByte    (twoByte)
  );

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      valueErrors++;
      $display("Error: %s expected %h got %h for bytes %h %h", name, exp, got,
               curBytes[15:8], curBytes[7:0]);
    end
  endtask

  task automatic checkOp(input csOp_e got, input csOp_e exp);
    if (got !== exp) begin
      valueErrors++;
      $display("Error: op expected %h got %h for bytes %h %h", exp, got,
               curBytes[15:8], curBytes[7:0]);
    end
  endtask

  task automatic checkImm(input csImm_e got, input csImm_e exp);
    if (got !== exp) begin
      valueErrors++;
      $display("Error: immSize expected %h got %h for bytes %h %h", exp, got,
               curBytes[15:8], curBytes[7:0]);
    end
  endtask

  `include "csDecodeTests.svh"

  // Stops a run whose handshake never completes
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hbeedf235));  // Fixes every later draw of the run
    rst = 1'b1;
    inValid = 1'b0;
    byte1 = '0;
    byte2 = '0;
    curBytes = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (outValid !== 1'b0) begin
      handshakeErrors++;
      $display("outValid is not low after reset");
    end
    testAlu();
    testMov();
    testControl();
    testShiftNot();
    testMiss();
    testBackToBack();
    $display("Summary: %0d value errors, %0d handshake errors", valueErrors,
             handshakeErrors);
    if (valueErrors + handshakeErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
+incdir+testbench
rtl/csDecodePkg.sv
rtl/opcodeMatch.sv
rtl/controlStore.sv
rtl/csDecode.sv
testbench/csDecodeTb.sv
